// ==== Bender.yml ====
package:
  name: rvfi_mem_check

sources:
  - files:
      - rtl/rvfi_check_pkg.sv
      - rtl/fifo_peek_if.sv
      - rtl/xfer_fifo.sv
      - rtl/mem_expect_builder.sv
      - rtl/rvfi_mem_compare.sv
      - rtl/check_status_regs.sv
      - rtl/rvfi_mem_check_top.sv
  - target: test
    files:
      - verification/tb_rvfi_mem_check.sv

// ==== rtl/check_status_regs.sv ====
// Monitor status registers
`timescale 1ns/1ps
`default_nettype none

module check_status_regs
  import rvfi_check_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mismatch_t             mismatch_i,
  input  logic                  clr_i,
  output mismatch_t             sticky_o,
  output logic [ERR_CNT_W-1:0]  error_count_o
);

  mismatch_t             sticky_q;
  logic [ERR_CNT_W-1:0]  count_q;
  logic [ERR_CNT_W-1:0]  count_inc;
  logic                  any_flag;

  assign any_flag = |mismatch_i;

  // The visible status already includes the flag shown on mismatch_i this cycle
  assign sticky_o  = sticky_q | mismatch_i;
  assign count_inc = (any_flag && (count_q != '1)) ? count_q + 1'b1 : count_q;
  assign error_count_o = count_inc;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sticky_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      // A flag present during the clear survives it
      sticky_q <= mismatch_i;
      count_q  <= ERR_CNT_W'(any_flag);
    end else begin
      sticky_q <= sticky_o;
      count_q  <= count_inc;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fifo_peek_if.sv ====
// Transfer log peek interface
`timescale 1ns/1ps
`default_nettype none

interface fifo_peek_if
  import rvfi_check_pkg::*;
#(
  parameter type payload_t = logic
) ();

  // The two oldest entries, valid as far as level says
  payload_t             head;
  payload_t             next;
  logic [LOG_PTR_W:0]   level;
  // Entries to retire at the next clock edge, 0 to 2
  logic [1:0]           pop_cnt;

  modport fifo   (output head, output next, output level, input pop_cnt);
  modport reader (input head, input next, input level, output pop_cnt);

endinterface

`default_nettype wire

// ==== rtl/mem_expect_builder.sv ====
// Expected RVFI access builder
`timescale 1ns/1ps
`default_nettype none

module mem_expect_builder
  import rvfi_check_pkg::*;
(
  fifo_peek_if.reader  req_log,
  fifo_peek_if.reader  resp_log,
  input  rvfi_mem_t    cap_i,
  input  logic         cap_valid_i,
  output rvfi_mem_t    exp_o,
  output logic         short_o
);

  logic [1:0]        lsb;
  logic [BE_W-1:0]   cap_mask;
  logic              is_read;
  logic              split;
  logic [1:0]        need;
  logic [2:0]        shift2;
  logic [DATA_W-1:0] first_data;
  logic [DATA_W-1:0] second_data;
  logic [BE_W-1:0]   exp_mask;
  logic [DATA_W-1:0] exp_data;
  logic              exp_err;

  assign lsb      = req_log.head.addr[1:0];
  assign cap_mask = cap_i.rmask | cap_i.wmask;
  assign is_read  = |cap_i.rmask;

  // A misaligned access crossing the word boundary arrives as two transfers
  assign split  = (3'(lsb) + 3'($countones(cap_mask))) > 3'd4;
  assign need   = split ? 2'd2 : 2'd1;
  assign shift2 = 3'd4 - 3'(lsb);

  // Both logs must already hold every transfer of this access
  assign short_o = cap_valid_i &&
                   ((req_log.level < need) || (resp_log.level < need));

  assign req_log.pop_cnt  = (cap_valid_i && !short_o) ? need : 2'd0;
  assign resp_log.pop_cnt = (cap_valid_i && !short_o) ? need : 2'd0;

  // Loads take their bytes from the responses and stores from the requests
  assign first_data  = is_read ? resp_log.head.rdata : req_log.head.wdata;
  assign second_data = is_read ? resp_log.next.rdata : req_log.next.wdata;

  ////////////////////////////////////////////////////////////////////////////
  // Realignment and merge
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (split) begin
      exp_mask = (req_log.head.be >> lsb) | (req_log.next.be << shift2);
      exp_data = ((first_data & be_to_bits(req_log.head.be)) >> {lsb, 3'b000}) |
                 ((second_data & be_to_bits(req_log.next.be)) << {shift2, 3'b000});
      exp_err  = resp_log.head.err | resp_log.next.err;
    end else begin
      exp_mask = req_log.head.be >> lsb;
      exp_data = first_data >> {lsb, 3'b000};
      exp_err  = resp_log.head.err;
    end
  end

  always_comb begin
    exp_o = '0;
    if (cap_valid_i) begin
      // Both halves of a split share the address of the first request
      exp_o.addr = req_log.head.addr;
      exp_o.err  = exp_err;
      if (is_read) begin
        exp_o.rmask = exp_mask;
        exp_o.rdata = exp_data;
      end else begin
        exp_o.wmask = exp_mask;
        exp_o.wdata = exp_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rvfi_check_pkg.sv ====
// RVFI memory monitor definitions
`default_nettype none

package rvfi_check_pkg;

  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned BE_W      = 4;
  localparam int unsigned LOG_DEPTH = 8;
  localparam int unsigned LOG_PTR_W = $clog2(LOG_DEPTH);
  localparam int unsigned ERR_CNT_W = 8;

  // One granted OBI request as it appears on the data bus
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic              we;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } obi_resp_t;

  // Memory fields of one retired instruction
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   rmask;
    logic [BE_W-1:0]   wmask;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] wdata;
    logic              err;
  } rvfi_mem_t;

  typedef struct packed {
    logic addr;
    logic mask;
    logic data;
    logic err;
    logic missing;
  } mismatch_t;

  // Expands byte enables into a bit mask over the data word
  function automatic logic [DATA_W-1:0] be_to_bits(input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] bits;
    for (int i = 0; i < BE_W; i++) begin
      bits[8*i +: 8] = {8{be[i]}};
    end
    return bits;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/rvfi_mem_check_top.sv ====
// RVFI memory consistency monitor
`timescale 1ns/1ps
`default_nettype none

module rvfi_mem_check_top
  import rvfi_check_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  obi_req_i,
  input  logic                  obi_gnt_i,
  input  logic [ADDR_W-1:0]     obi_addr_i,
  input  logic [BE_W-1:0]       obi_be_i,
  input  logic                  obi_we_i,
  input  logic [DATA_W-1:0]     obi_wdata_i,
  input  logic                  obi_rvalid_i,
  input  logic [DATA_W-1:0]     obi_rdata_i,
  input  logic                  obi_err_i,

  input  logic                  rvfi_valid_i,
  input  logic [ADDR_W-1:0]     rvfi_mem_addr_i,
  input  logic [BE_W-1:0]       rvfi_mem_rmask_i,
  input  logic [BE_W-1:0]       rvfi_mem_wmask_i,
  input  logic [DATA_W-1:0]     rvfi_mem_rdata_i,
  input  logic [DATA_W-1:0]     rvfi_mem_wdata_i,
  input  logic                  rvfi_mem_err_i,

  input  logic                  status_clr_i,
  output mismatch_t             mismatch_o,
  output mismatch_t             sticky_o,
  output logic [ERR_CNT_W-1:0]  error_count_o
);

  obi_req_t  obi_req;
  obi_resp_t obi_resp;
  rvfi_mem_t rvfi_mem;
  rvfi_mem_t cap;
  rvfi_mem_t exp_mem;
  logic      cap_valid;
  logic      short_log;
  logic      req_push;
  mismatch_t mismatch;

  fifo_peek_if #(.payload_t(obi_req_t))  req_log_if  ();
  fifo_peek_if #(.payload_t(obi_resp_t)) resp_log_if ();

  assign req_push = obi_req_i && obi_gnt_i;

  assign obi_req  = '{addr: obi_addr_i, be: obi_be_i, we: obi_we_i, wdata: obi_wdata_i};
  assign obi_resp = '{rdata: obi_rdata_i, err: obi_err_i};
  assign rvfi_mem = '{addr: rvfi_mem_addr_i, rmask: rvfi_mem_rmask_i,
                      wmask: rvfi_mem_wmask_i, rdata: rvfi_mem_rdata_i,
                      wdata: rvfi_mem_wdata_i, err: rvfi_mem_err_i};

  ////////////////////////////////////////////////////////////////////////////
  // Transfer logs
  ////////////////////////////////////////////////////////////////////////////

  xfer_fifo #(.payload_t(obi_req_t)) u_req_log (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (req_push),
    .data_i (obi_req),
    .peek   (req_log_if.fifo)
  );

  xfer_fifo #(.payload_t(obi_resp_t)) u_resp_log (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (obi_rvalid_i),
    .data_i (obi_resp),
    .peek   (resp_log_if.fifo)
  );

  mem_expect_builder u_builder (
    .req_log     (req_log_if.reader),
    .resp_log    (resp_log_if.reader),
    .cap_i       (cap),
    .cap_valid_i (cap_valid),
    .exp_o       (exp_mem),
    .short_o     (short_log)
  );

  rvfi_mem_compare u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rvfi_valid_i (rvfi_valid_i),
    .rvfi_mem_i   (rvfi_mem),
    .exp_i        (exp_mem),
    .short_i      (short_log),
    .cap_o        (cap),
    .cap_valid_o  (cap_valid),
    .mismatch_o   (mismatch)
  );

  check_status_regs u_status (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mismatch_i    (mismatch),
    .clr_i         (status_clr_i),
    .sticky_o      (sticky_o),
    .error_count_o (error_count_o)
  );

  assign mismatch_o = mismatch;

endmodule

`default_nettype wire

// ==== rtl/rvfi_mem_compare.sv ====
// Retired access comparator
`timescale 1ns/1ps
`default_nettype none

module rvfi_mem_compare
  import rvfi_check_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rvfi_valid_i,
  input  rvfi_mem_t  rvfi_mem_i,
  input  rvfi_mem_t  exp_i,
  input  logic       short_i,
  output rvfi_mem_t  cap_o,
  output logic       cap_valid_o,
  output mismatch_t  mismatch_o
);

  rvfi_mem_t cap_q;
  logic      cap_valid_q;
  logic      has_mem;
  mismatch_t mismatch_d;
  mismatch_t mismatch_q;

  // Instructions without a memory access are not checked
  assign has_mem = |(rvfi_mem_i.rmask | rvfi_mem_i.wmask);

  always_ff @(posedge clk_i) begin
    if (rvfi_valid_i && has_mem) begin
      cap_q <= rvfi_mem_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_valid_q <= 1'b0;
      mismatch_q  <= '0;
    end else begin
      cap_valid_q <= rvfi_valid_i && has_mem;
      mismatch_q  <= mismatch_d;
    end
  end

  // A missing transfer masks every other comparison
  always_comb begin
    mismatch_d = '0;
    if (cap_valid_q) begin
      if (short_i) begin
        mismatch_d.missing = 1'b1;
      end else begin
        mismatch_d.addr = cap_q.addr != exp_i.addr;
        mismatch_d.mask = (cap_q.rmask != exp_i.rmask) || (cap_q.wmask != exp_i.wmask);
        // Bytes outside the reported mask carry no meaning
        mismatch_d.data = (((cap_q.rdata ^ exp_i.rdata) & be_to_bits(cap_q.rmask)) != '0) ||
                          (((cap_q.wdata ^ exp_i.wdata) & be_to_bits(cap_q.wmask)) != '0);
        mismatch_d.err  = cap_q.err != exp_i.err;
      end
    end
  end

  assign cap_o       = cap_q;
  assign cap_valid_o = cap_valid_q;
  assign mismatch_o  = mismatch_q;

  // One memory operation per instruction, so a retirement is a load or a store
  a_single_direction : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cap_valid_q |-> !((|cap_q.rmask) && (|cap_q.wmask)));

endmodule

`default_nettype wire

// ==== rtl/xfer_fifo.sv ====
// OBI transfer log
`timescale 1ns/1ps
`default_nettype none

module xfer_fifo
  import rvfi_check_pkg::*;
#(
  parameter type payload_t = obi_req_t
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        push_i,
  input  payload_t    data_i,
  fifo_peek_if.fifo   peek
);

  payload_t               mem [LOG_DEPTH];
  logic [LOG_PTR_W-1:0]   wr_ptr_q;
  logic [LOG_PTR_W-1:0]   rd_ptr_q;
  logic [LOG_PTR_W-1:0]   rd_ptr_nxt;
  logic [LOG_PTR_W:0]     level_q;

  // Depth is a power of two so the pointers wrap on their own
  assign rd_ptr_nxt = rd_ptr_q + 1'b1;

  assign peek.head  = mem[rd_ptr_q];
  assign peek.next  = mem[rd_ptr_nxt];
  assign peek.level = level_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      rd_ptr_q <= rd_ptr_q + LOG_PTR_W'(peek.pop_cnt);
      level_q  <= level_q + (LOG_PTR_W+1)'(push_i) - (LOG_PTR_W+1)'(peek.pop_cnt);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Log integrity
  ////////////////////////////////////////////////////////////////////////////

  // A full log only accepts a transfer when the builder retires one at the same edge
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push_i && (level_q == LOG_DEPTH)) |-> (peek.pop_cnt != 2'd0));

  // The builder never retires entries that have not been logged yet
  a_no_overpop : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (LOG_PTR_W+1)'(peek.pop_cnt) <= level_q);

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/rvfi_check_pkg.sv
rtl/fifo_peek_if.sv
rtl/xfer_fifo.sv
rtl/mem_expect_builder.sv
rtl/rvfi_mem_compare.sv
rtl/check_status_regs.sv
rtl/rvfi_mem_check_top.sv
verification/tb_rvfi_mem_check.sv

// ==== verification/tb_rvfi_mem_check.sv ====
// RVFI memory monitor testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rvfi_mem_check
  import rvfi_check_pkg::*;
();

  // Reset and six tests take roughly this many cycles
  localparam int unsigned TEST_CYCLES    = 100;
  localparam int unsigned TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  localparam mismatch_t NO_FLAG      = '0;
  localparam mismatch_t DATA_FLAG    = '{data: 1'b1, default: 1'b0};
  localparam mismatch_t ERR_FLAG     = '{err: 1'b1, default: 1'b0};
  localparam mismatch_t MISSING_FLAG = '{missing: 1'b1, default: 1'b0};

  logic                  clk;
  logic                  rst_n;
  logic                  obi_req;
  logic                  obi_gnt;
  logic [ADDR_W-1:0]     obi_addr;
  logic [BE_W-1:0]       obi_be;
  logic                  obi_we;
  logic [DATA_W-1:0]     obi_wdata;
  logic                  obi_rvalid;
  logic [DATA_W-1:0]     obi_rdata;
  logic                  obi_err;
  logic                  rvfi_valid;
  logic [ADDR_W-1:0]     rvfi_addr;
  logic [BE_W-1:0]       rvfi_rmask;
  logic [BE_W-1:0]       rvfi_wmask;
  logic [DATA_W-1:0]     rvfi_rdata;
  logic [DATA_W-1:0]     rvfi_wdata;
  logic                  rvfi_err;
  logic                  status_clr;
  mismatch_t             mismatch;
  mismatch_t             sticky;
  logic [ERR_CNT_W-1:0]  error_count;

  // Expected flags travel with each retirement and reach the outputs two edges later
  mismatch_t             mis_drv;
  mismatch_t             mis_q;
  mismatch_t             mis_exp;
  mismatch_t             sticky_exp;
  logic [ERR_CNT_W-1:0]  count_exp;
  logic [ERR_CNT_W-1:0]  count_base;
  logic [ERR_CNT_W-1:0]  count_next;
  logic                  ret_q;

  integer                seed = 9467;
  int unsigned           cycle_cnt = 0;
  int unsigned           err_cnt = 0;
  int unsigned           err_at_start;
  int unsigned           test_num = 0;
  int unsigned           tests_passed = 0;
  int unsigned           tests_failed = 0;
  logic [DATA_W-1:0]     rd0;
  logic [DATA_W-1:0]     rd1;
  logic [DATA_W-1:0]     wd;

  rvfi_mem_check_top u_rvfi_mem_check_top (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .obi_req_i        (obi_req),
    .obi_gnt_i        (obi_gnt),
    .obi_addr_i       (obi_addr),
    .obi_be_i         (obi_be),
    .obi_we_i         (obi_we),
    .obi_wdata_i      (obi_wdata),
    .obi_rvalid_i     (obi_rvalid),
    .obi_rdata_i      (obi_rdata),
    .obi_err_i        (obi_err),
    .rvfi_valid_i     (rvfi_valid),
    .rvfi_mem_addr_i  (rvfi_addr),
    .rvfi_mem_rmask_i (rvfi_rmask),
    .rvfi_mem_wmask_i (rvfi_wmask),
    .rvfi_mem_rdata_i (rvfi_rdata),
    .rvfi_mem_wdata_i (rvfi_wdata),
    .rvfi_mem_err_i   (rvfi_err),
    .status_clr_i     (status_clr),
    .mismatch_o       (mismatch),
    .sticky_o         (sticky),
    .error_count_o    (error_count)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Expected status
  ////////////////////////////////////////////////////////////////////////////

  // A clear keeps only the flags shown in the clear cycle and the next one
  always_comb begin
    count_base = status_clr ? ERR_CNT_W'(|mis_exp) : count_exp;
    count_next = count_base;
    if ((|mis_q) && (count_base != '1)) begin
      count_next = count_base + 1'b1;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ret_q      <= 1'b0;
      mis_q      <= '0;
      mis_exp    <= '0;
      sticky_exp <= '0;
      count_exp  <= '0;
    end else begin
      ret_q      <= rvfi_valid;
      mis_q      <= mis_drv;
      mis_exp    <= mis_q;
      sticky_exp <= (status_clr ? mis_exp : sticky_exp) | mis_q;
      count_exp  <= count_next;
    end
  end

  a_mismatch : assert property (@(posedge clk) disable iff (!rst_n) mismatch == mis_exp)
    else begin
      $display("** Error at %0t: mismatch_o expected %b, actual %b",
               $time, $sampled(mis_exp), $sampled(mismatch));
      err_cnt = err_cnt + 1;
    end

  a_sticky : assert property (@(posedge clk) disable iff (!rst_n) sticky == sticky_exp)
    else begin
      $display("** Error at %0t: sticky_o expected %b, actual %b",
               $time, $sampled(sticky_exp), $sampled(sticky));
      err_cnt = err_cnt + 1;
    end

  a_count : assert property (@(posedge clk) disable iff (!rst_n) error_count == count_exp)
    else begin
      $display("** Error at %0t: error_count_o expected %0d, actual %0d",
               $time, $sampled(count_exp), $sampled(error_count));
      err_cnt = err_cnt + 1;
    end

  // A clear with no flag on the way leaves the whole status at zero
  a_clear : assert property (@(posedge clk) disable iff (!rst_n)
    (status_clr && (mis_exp == '0) && (mis_q == '0)) |=>
      ((sticky == '0) && (error_count == '0)))
    else begin
      $display("** Error at %0t: sticky_o expected %b, actual %b",
               $time, NO_FLAG, $sampled(sticky));
      $display("** Error at %0t: error_count_o expected 0, actual %0d",
               $time, $sampled(error_count));
      err_cnt = err_cnt + 1;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic obi_request(input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                             input logic we, input logic [DATA_W-1:0] wdata);
    obi_req   = 1'b1;
    obi_gnt   = 1'b1;
    obi_addr  = addr;
    obi_be    = be;
    obi_we    = we;
    obi_wdata = wdata;
    @(negedge clk);
    obi_req   = 1'b0;
    obi_gnt   = 1'b0;
  endtask

  task automatic obi_response(input logic [DATA_W-1:0] rdata, input logic err);
    obi_rvalid = 1'b1;
    obi_rdata  = rdata;
    obi_err    = err;
    @(negedge clk);
    obi_rvalid = 1'b0;
    obi_err    = 1'b0;
  endtask

  task automatic retire_access(input logic [ADDR_W-1:0] addr,
                               input logic [BE_W-1:0]   rmask,
                               input logic [BE_W-1:0]   wmask,
                               input logic [DATA_W-1:0] rdata,
                               input logic [DATA_W-1:0] wdata,
                               input logic              err,
                               input mismatch_t         flags);
    rvfi_valid = 1'b1;
    rvfi_addr  = addr;
    rvfi_rmask = rmask;
    rvfi_wmask = wmask;
    rvfi_rdata = rdata;
    rvfi_wdata = wdata;
    rvfi_err   = err;
    mis_drv    = flags;
    @(negedge clk);
    rvfi_valid = 1'b0;
    mis_drv    = '0;
  endtask

  // Returns once the last retirement's result has been checked
  task automatic wait_checks();
    do @(negedge clk); while (ret_q);
    @(negedge clk);
  endtask

  task automatic pulse_clear();
    status_clr = 1'b1;
    @(negedge clk);
    status_clr = 1'b0;
    @(negedge clk);
  endtask

  task automatic start_test();
    test_num     = test_num + 1;
    err_at_start = err_cnt;
  endtask

  task automatic report_test(input string name);
    if (err_cnt == err_at_start) begin
      tests_passed = tests_passed + 1;
      $display("Test %0d (%s): PASS", test_num, name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("Test %0d (%s): FAIL", test_num, name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    obi_req    = 1'b0;
    obi_gnt    = 1'b0;
    obi_addr   = '0;
    obi_be     = '0;
    obi_we     = 1'b0;
    obi_wdata  = '0;
    obi_rvalid = 1'b0;
    obi_rdata  = '0;
    obi_err    = 1'b0;
    rvfi_valid = 1'b0;
    rvfi_addr  = '0;
    rvfi_rmask = '0;
    rvfi_wmask = '0;
    rvfi_rdata = '0;
    rvfi_wdata = '0;
    rvfi_err   = 1'b0;
    status_clr = 1'b0;
    mis_drv    = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    start_test();
    wd = $random(seed);
    obi_request(32'h0000_0100, 4'hf, 1'b1, wd);
    obi_response('0, 1'b0);
    retire_access(32'h0000_0100, 4'h0, 4'hf, '0, wd, 1'b0, NO_FLAG);
    wait_checks();
    report_test("aligned word write");

    // Upper halfword moves down to byte lane 0
    start_test();
    rd0 = $random(seed);
    obi_request(32'h0000_0206, 4'b1100, 1'b0, '0);
    obi_response(rd0, 1'b0);
    retire_access(32'h0000_0206, 4'b0011, 4'h0, {16'h0000, rd0[31:16]}, '0, 1'b0, NO_FLAG);
    wait_checks();
    report_test("halfword read at offset 2");

    // Byte 3 of the first word, then bytes 0 to 2 of the next
    start_test();
    rd0 = $random(seed);
    rd1 = $random(seed);
    obi_request(32'h0000_0303, 4'b1000, 1'b0, '0);
    obi_request(32'h0000_0304, 4'b0111, 1'b0, '0);
    obi_response(rd0, 1'b0);
    obi_response(rd1, 1'b1);
    retire_access(32'h0000_0303, 4'hf, 4'h0, {rd1[23:0], rd0[31:24]}, '0, 1'b1, NO_FLAG);
    rd0 = $random(seed);
    rd1 = $random(seed);
    obi_request(32'h0000_0303, 4'b1000, 1'b0, '0);
    obi_request(32'h0000_0304, 4'b0111, 1'b0, '0);
    obi_response(rd0, 1'b0);
    obi_response(rd1, 1'b1);
    retire_access(32'h0000_0303, 4'hf, 4'h0, {rd1[23:0], rd0[31:24]}, '0, 1'b0, ERR_FLAG);
    wait_checks();
    report_test("split misaligned word read");

    start_test();
    rd0 = $random(seed);
    obi_request(32'h0000_0400, 4'hf, 1'b0, '0);
    obi_response(rd0, 1'b0);
    retire_access(32'h0000_0400, 4'hf, 4'h0, rd0 ^ 32'h0000_ff00, '0, 1'b0, DATA_FLAG);
    rd1 = $random(seed);
    obi_request(32'h0000_0404, 4'b0001, 1'b0, '0);
    obi_response(rd1, 1'b0);
    retire_access(32'h0000_0404, 4'b0001, 4'h0, rd1 ^ 32'hff00_0000, '0, 1'b0, NO_FLAG);
    wait_checks();
    report_test("corrupted byte inside and outside the mask");

    start_test();
    rd0 = $random(seed);
    rd1 = $random(seed);
    obi_request(32'h0000_0500, 4'hf, 1'b0, '0);
    obi_request(32'h0000_0504, 4'hf, 1'b0, '0);
    retire_access(32'h0000_0500, 4'hf, 4'h0, rd0, '0, 1'b0, MISSING_FLAG);
    obi_response(rd0, 1'b0);
    obi_response(rd1, 1'b0);
    retire_access(32'h0000_0500, 4'hf, 4'h0, rd0, '0, 1'b0, NO_FLAG);
    retire_access(32'h0000_0504, 4'hf, 4'h0, rd1, '0, 1'b0, NO_FLAG);
    wait_checks();
    report_test("early retirement then back-to-back retirements");

    start_test();
    pulse_clear();
    report_test("status clear");

    $display("Tests run: %0d, passed: %0d, failed: %0d, assertion errors: %0d",
             test_num, tests_passed, tests_failed, err_cnt);
    if ((tests_failed == 0) && (err_cnt == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
